// File: Makefile
# Verilator build and run of the core testbench
TOP = coreTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f $(wildcard common/*.sv fetch/*.sv source/*.sv testbench/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f

# pass only when the testbench prints its pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

// File: common/corePkg.sv
/* Shared widths, opcode encodings and pipeline stage records for the core.
   Every core module imports this package in its header. */
`default_nettype none

package corePkg;

   localparam int dataWidth = 64; // register and bus word
   localparam int regCount = 16;
   localparam int regIdxWidth = 4;

   localparam int lineBytes = 64; // one bus request
   localparam int beatBytes = 8; // one response beat
   localparam int bufferBytes = 128; // circular decode buffer
   localparam int offsetWidth = 7; // index into the decode buffer

   localparam int maxInstrLen = 6; // longest instruction, bytes needed before decode
   localparam int immWidth = 32;
   localparam int lenWidth = $clog2(maxInstrLen + 1); // holds 0 to maxInstrLen

   // opcode byte values, x86 flavoured
   typedef enum logic [7:0] {
      opNop = 8'h90,
      opAdd = 8'h01, // dest += src
      opSub = 8'h29, // dest -= src
      opMovImm = 8'hB8, // dest = imm
      opAddImm = 8'h81 // dest += imm
   } opcodeT;

   typedef enum logic [1:0] {
      fetchIdle,
      fetchWaiting, // request accepted, no beat yet
      fetchActive // beats arriving
   } fetchStateT;

   // decode latch contents
   typedef struct packed {
      logic valid;
      opcodeT opcode;
      logic [regIdxWidth-1:0] destReg;
      logic [regIdxWidth-1:0] srcReg;
      logic useSrc; // reads srcReg
      logic useDest; // writes destReg
      logic [immWidth-1:0] imm;
   } decodedInstT;

   // read stage to execute
   typedef struct packed {
      logic valid;
      opcodeT opcode;
      logic [regIdxWidth-1:0] destReg;
      logic [dataWidth-1:0] destVal; // current value of destReg
      logic [dataWidth-1:0] operand; // source value or immediate
   } operandT;

   // retired result, one cycle pulse
   typedef struct packed {
      logic valid;
      logic [regIdxWidth-1:0] regIdx;
      logic [dataWidth-1:0] data;
   } writebackT;

endpackage

`default_nettype wire

// File: fetch/fetchUnit.sv
/* Fetches 64-byte lines over the bus into a circular decode buffer and presents
   the next instruction window to the decoder. */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import corePkg::*; (
   input logic bus,
   input logic rst,
   input logic [dataWidth-1:0] entry,
   output logic reqCyc,
   output logic [dataWidth-1:0] reqAddr,
   input logic reqAck,
   input logic respCyc,
   input logic [dataWidth-1:0] resp,
   input logic [lenWidth-1:0] bytesConsumed,
   output logic [maxInstrLen-1:0][7:0] window,
   output logic windowValid
);

   fetchStateT state;
   logic [dataWidth-1:0] fetchAddr; // address of the next beat
   logic [dataWidth-1:0] lineMask;
   logic [offsetWidth-1:0] fetchOffset, decodeOffset;
   logic [offsetWidth:0] fillCount; // bytes buffered, reaches bufferBytes
   logic [offsetWidth:0] fillAdd, fillSub;
   logic [7:0] buffer [bufferBytes];
   logic beatStore;
   logic lastBeat;
   logic canRequest;

   assign lineMask = ~dataWidth'(lineBytes - 1);
   assign reqAddr = fetchAddr & lineMask;

   // words below the entry word are dropped
   assign beatStore = respCyc && (fetchAddr[dataWidth-1:3] >= entry[dataWidth-1:3]);
   assign lastBeat = respCyc && (&fetchAddr[5:3]); // last word of the line
   assign canRequest = fillCount <= (offsetWidth + 1)'(bufferBytes - lineBytes);

   assign fillAdd = beatStore ? (offsetWidth + 1)'(beatBytes) : '0;
   assign fillSub = (offsetWidth + 1)'(bytesConsumed);

   always_ff @(posedge bus) begin
      if (rst) begin
         state <= fetchIdle;
         reqCyc <= 1'b0;
         fetchAddr <= entry & lineMask;
         fetchOffset <= '0;
         decodeOffset <= '0;
         fillCount <= '0;
      end else begin
         case (state)
            fetchIdle: begin
               if (reqCyc && reqAck) begin
                  reqCyc <= 1'b0;
                  state <= fetchWaiting;
               end else if (!reqCyc && canRequest) begin
                  reqCyc <= 1'b1;
               end
            end
            fetchWaiting: begin
               if (respCyc) state <= fetchActive;
            end
            fetchActive: begin
               if (lastBeat) state <= fetchIdle; // fetchAddr now points at next line
            end
            default: state <= fetchIdle;
         endcase

         if (respCyc) fetchAddr <= fetchAddr + dataWidth'(beatBytes);
         if (beatStore) fetchOffset <= fetchOffset + offsetWidth'(beatBytes);

         decodeOffset <= decodeOffset + offsetWidth'(bytesConsumed);
         fillCount <= fillCount + fillAdd - fillSub;
      end
   end

   // buffer storage, little-endian bytes within the beat
   always_ff @(posedge bus) begin
      if (beatStore) begin
         for (int i = 0; i < beatBytes; i++) begin
            buffer[fetchOffset + offsetWidth'(i)] <= resp[8*i +: 8];
         end
      end
   end

   // window wraps around the end of the buffer
   always_comb begin
      logic [offsetWidth-1:0] rdIdx;
      for (int i = 0; i < maxInstrLen; i++) begin
         rdIdx = decodeOffset + offsetWidth'(i);
         window[i] = buffer[rdIdx];
      end
   end

   assign windowValid = fillCount >= (offsetWidth + 1)'(maxInstrLen);

endmodule

`default_nettype wire

// File: source/aluExecute.sv
/* Execute stage. Computes the result for the latched operands and registers it
   as the write-back record. */
`timescale 1ns/1ps
`default_nettype none

module aluExecute import corePkg::*; (
   input logic bus,
   input logic rst,
   input operandT operand,
   output writebackT wb
);

   logic [dataWidth-1:0] result;

   always_comb begin
      case (operand.opcode)
         opAdd, opAddImm: result = operand.destVal + operand.operand; // wraps at 64 bits
         opSub: result = operand.destVal - operand.operand;
         opMovImm: result = operand.operand;
         default: result = operand.destVal; // nop leaves it alone
      endcase
   end

   always_ff @(posedge bus) begin
      if (rst) begin
         wb.valid <= 1'b0;
      end else begin
         wb.valid <= operand.valid && (operand.opcode != opNop); // nop writes nothing
         wb.regIdx <= operand.destReg;
         wb.data <= result;
      end
   end

endmodule

`default_nettype wire

// File: source/coreTop.sv
/* Top of the in-order core. Connects fetch, decode, scoreboard, read and
   execute to the bus and the write-back output. */
`timescale 1ns/1ps
`default_nettype none

module coreTop import corePkg::*; (
   input logic bus,
   input logic rst,
   input logic [dataWidth-1:0] entry,
   output logic reqCyc,
   output logic [dataWidth-1:0] reqAddr,
   input logic reqAck,
   input logic respCyc,
   input logic [dataWidth-1:0] resp,
   output writebackT wb
);

   logic [maxInstrLen-1:0][7:0] window;
   logic windowValid;
   logic [lenWidth-1:0] bytesConsumed;
   decodedInstT decoded;
   logic stall;
   logic issue;
   operandT operand;

   fetchUnit fetch (
      .bus, .rst, .entry,
      .reqCyc, .reqAddr, .reqAck, .respCyc, .resp,
      .bytesConsumed, .window, .windowValid
   );

   instDecoder decoder (
      .bus, .rst, .window, .windowValid, .stall,
      .bytesConsumed, .decoded
   );

   scoreboard board (
      .bus, .rst, .decoded, .wb, .stall, .issue
   );

   regRead read (
      .bus, .rst, .decoded, .issue, .wb, .operand
   );

   aluExecute execute (
      .bus, .rst, .operand, .wb
   );

endmodule

`default_nettype wire

// File: source/instDecoder.sv
/* Decodes the instruction at the head of the fetch window into the decode latch
   and tells fetch how many bytes were taken. */
`timescale 1ns/1ps
`default_nettype none

module instDecoder import corePkg::*; (
   input logic bus,
   input logic rst,
   input logic [maxInstrLen-1:0][7:0] window,
   input logic windowValid,
   input logic stall,
   output logic [lenWidth-1:0] bytesConsumed,
   output decodedInstT decoded
);

   decodedInstT nextInst;
   logic [lenWidth-1:0] instLen;
   logic known;

   always_comb begin
      nextInst = '0;
      nextInst.opcode = opcodeT'(window[0]);
      nextInst.destReg = window[1][7:4];
      nextInst.srcReg = window[1][3:0];
      nextInst.imm = {window[5], window[4], window[3], window[2]}; // little-endian
      known = 1'b1;
      instLen = lenWidth'(1);
      case (window[0])
         opNop: begin
            instLen = lenWidth'(1);
         end
         opAdd, opSub: begin
            instLen = lenWidth'(2);
            nextInst.useSrc = 1'b1;
            nextInst.useDest = 1'b1;
         end
         opMovImm, opAddImm: begin
            instLen = lenWidth'(maxInstrLen);
            nextInst.useDest = 1'b1;
         end
         default: begin
            known = 1'b0; // skipped as a single byte
         end
      endcase
      nextInst.valid = known;
   end

   // nothing is taken while the latch is held
   assign bytesConsumed = (windowValid && !stall) ? instLen : '0;

   always_ff @(posedge bus) begin
      if (rst) begin
         decoded.valid <= 1'b0;
      end else if (!stall) begin
         if (windowValid && known) begin
            decoded <= nextInst;
         end else begin
            decoded.valid <= 1'b0; // empty or unknown byte
         end
      end
   end

endmodule

`default_nettype wire

// File: source/regRead.sv
/* Register file with its write-back port, plus the operand latch that feeds
   execute with the destination value and the second operand. */
`timescale 1ns/1ps
`default_nettype none

module regRead import corePkg::*; (
   input logic bus,
   input logic rst,
   input decodedInstT decoded,
   input logic issue,
   input writebackT wb,
   output operandT operand
);

   logic [dataWidth-1:0] regFile [regCount];
   logic [dataWidth-1:0] secondVal;

   // register source for add and sub, immediate otherwise
   assign secondVal = decoded.useSrc ? regFile[decoded.srcReg]
                                     : dataWidth'(decoded.imm);

   always_ff @(posedge bus) begin
      if (rst) begin
         for (int i = 0; i < regCount; i++) begin
            regFile[i] <= '0;
         end
      end else if (wb.valid) begin
         regFile[wb.regIdx] <= wb.data;
      end
   end

   always_ff @(posedge bus) begin
      if (rst) begin
         operand.valid <= 1'b0;
      end else begin
         operand.valid <= issue;
         if (issue) begin
            operand.opcode <= decoded.opcode;
            operand.destReg <= decoded.destReg;
            operand.destVal <= regFile[decoded.destReg];
            operand.operand <= secondVal;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/scoreboard.sv
/* Register in-use tracking. Holds the decode latch on a hazard and issues it
   to the read stage once its registers are free. */
`timescale 1ns/1ps
`default_nettype none

module scoreboard import corePkg::*; (
   input logic bus,
   input logic rst,
   input decodedInstT decoded,
   input writebackT wb,
   output logic stall,
   output logic issue
);

   logic [regCount-1:0] inUse; // one bit per register with a result in flight
   logic hazard;

   // a register cleared this cycle still blocks, so dependents wait one more cycle
   assign hazard = (decoded.useSrc && inUse[decoded.srcReg])
                || (decoded.useDest && inUse[decoded.destReg]);

   assign stall = decoded.valid && hazard;
   assign issue = decoded.valid && !hazard;

   always_ff @(posedge bus) begin
      if (rst) begin
         inUse <= '0;
      end else begin
         if (wb.valid) inUse[wb.regIdx] <= 1'b0;
         // never the same register as wb, issue needs it free
         if (issue && decoded.useDest) inUse[decoded.destReg] <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: testbench/coreTb.sv
/* Testbench for coreTop. A byte memory serves fetch requests and each retirement is
   compared with an in-order reference model of the program. */
`timescale 1ns/1ps
`default_nettype none

module coreTb import corePkg::*; ();

   localparam int memAddrWidth = 11;
   localparam int memBytes = 1 << memAddrWidth; // addresses repeat every 2 KiB
   localparam int cycleLimit = 5 * 4000; // 4000 cycles for each of the five tests
   localparam int tailNops = 8; // nop bytes placed after each program
   localparam logic [7:0] nopByte = 8'h90;
   localparam logic [7:0] addByte = 8'h01;
   localparam logic [7:0] subByte = 8'h29;
   localparam logic [7:0] movImmByte = 8'hB8;
   localparam logic [7:0] addImmByte = 8'h81;

   typedef enum {memIdle, memAckWait, memBeats} memStateT;

   logic bus;
   logic rst;
   logic [dataWidth-1:0] entry;
   logic reqCyc;
   logic [dataWidth-1:0] reqAddr;
   logic reqAck;
   logic respCyc;
   logic [dataWidth-1:0] resp;
   writebackT wb;

   logic [7:0] mem [memBytes];
   logic [dataWidth-1:0] modelRegs [regCount];
   logic [regIdxWidth+dataWidth-1:0] expQ [$]; // {reg, data} in retire order
   int firstReqAddr;
   logic sawReq;
   logic checking; // monitor compares only while a program runs
   int errors;
   int cycles;
   int progPtr;

   coreTop dut (
      .bus, .rst, .entry, .reqCyc, .reqAddr, .reqAck, .respCyc, .resp, .wb
   );

   initial begin
      bus = 1'b0;
      forever #4 bus = ~bus;
   end

   initial begin
      cycles = 0;
      while (cycles < cycleLimit) begin
         @(posedge bus);
         cycles++;
      end
      $display("timeout: run still busy after %0d cycles, %0d errors", cycleLimit, errors);
      $display("ERRORS FOUND");
      $finish;
   end

   function automatic logic [memAddrWidth-1:0] memIdx(input int addr);
      return memAddrWidth'(addr);
   endfunction

   function automatic logic [dataWidth-1:0] readWord(input int addr);
      logic [dataWidth-1:0] w;
      for (int b = 0; b < beatBytes; b++) begin
         w[8*b +: 8] = mem[memIdx(addr + b)]; // little-endian by address
      end
      return w;
   endfunction

   function automatic int pickReg(input int count);
      return int'($urandom % count);
   endfunction

   // acks after 0 to 3 cycles, then sends 8 beats with random single-cycle gaps
   initial begin
      memStateT state;
      int delay;
      int beat;
      int lineAddr;
      logic gapped;
      logic nextAck;
      logic nextCyc;
      logic [dataWidth-1:0] nextResp;
      reqAck = 1'b0;
      respCyc = 1'b0;
      resp = '0;
      state = memIdle;
      delay = 0;
      beat = 0;
      lineAddr = 0;
      gapped = 1'b0;
      sawReq = 1'b0;
      firstReqAddr = 0;
      forever begin
         @(negedge bus);
         nextAck = 1'b0;
         nextCyc = 1'b0;
         nextResp = '0;
         if (rst) begin
            state = memIdle;
            sawReq = 1'b0;
         end else begin
            if (state == memIdle && reqCyc) begin
               lineAddr = int'(reqAddr);
               if (!sawReq) firstReqAddr = lineAddr;
               sawReq = 1'b1;
               delay = int'($urandom % 4);
               state = memAckWait;
            end
            if (state == memAckWait) begin
               if (delay == 0) begin
                  nextAck = 1'b1;
                  beat = 0;
                  gapped = 1'b0;
                  state = memBeats;
               end else begin
                  delay--;
               end
            end else if (state == memBeats) begin
               if (!gapped && $urandom % 4 == 0) begin
                  gapped = 1'b1; // idle cycle between beats
               end else begin
                  gapped = 1'b0;
                  nextCyc = 1'b1;
                  nextResp = readWord(lineAddr + beatBytes * beat);
                  beat++;
                  if (beat == lineBytes / beatBytes) state = memIdle;
               end
            end
         end
         @(posedge bus);
         #1;
         reqAck = nextAck;
         respCyc = nextCyc;
         resp = nextResp;
      end
   end

   initial begin
      logic [regIdxWidth+dataWidth-1:0] expected;
      forever begin
         @(negedge bus);
         if (checking && wb.valid) begin
            if (expQ.size() == 0) begin
               errors++;
               $display("FAIL %0t: unexpected write-back to r%0d", $time, wb.regIdx);
            end else begin
               expected = expQ.pop_front();
               if (wb.regIdx !== expected[dataWidth +: regIdxWidth]
                     || wb.data !== expected[dataWidth-1:0]) begin
                  errors++;
                  $display("FAIL %0t: wb r%0d = %h, expected r%0d = %h", $time, wb.regIdx,
                     wb.data, expected[dataWidth +: regIdxWidth], expected[dataWidth-1:0]);
               end
            end
         end
      end
   end

   task automatic fillMemory();
      for (int a = 0; a < memBytes; a++) begin
         mem[memIdx(a)] = 8'(a) ^ 8'(a >> 8) ^ 8'h3C; // every address bit shows
      end
   endtask

   task automatic putInst(input logic [7:0] op, input int d, input int s,
                          input logic [31:0] imm);
      mem[memIdx(progPtr)] = op;
      if (op == addByte || op == subByte) begin
         mem[memIdx(progPtr + 1)] = {4'(d), 4'(s)};
         progPtr += 2;
      end else if (op == movImmByte || op == addImmByte) begin
         mem[memIdx(progPtr + 1)] = {4'(d), 4'(s)};
         for (int b = 0; b < 4; b++) begin
            mem[memIdx(progPtr + 2 + b)] = imm[8*b +: 8];
         end
         progPtr += 6;
      end else begin
         progPtr += 1; // nop or a byte outside the opcode set
      end
   endtask

   // executes the program from memory and queues the expected write-backs
   task automatic runModel(input int startAddr, input int endAddr);
      int pc;
      int len;
      logic [7:0] op;
      logic [regIdxWidth-1:0] d;
      logic [regIdxWidth-1:0] s;
      logic [dataWidth-1:0] imm;
      for (int r = 0; r < regCount; r++) begin
         modelRegs[r] = '0;
      end
      pc = startAddr;
      while (pc < endAddr) begin
         op = mem[memIdx(pc)];
         d = mem[memIdx(pc + 1)][7:4];
         s = mem[memIdx(pc + 1)][3:0];
         imm = {32'h0, mem[memIdx(pc + 5)], mem[memIdx(pc + 4)],
                mem[memIdx(pc + 3)], mem[memIdx(pc + 2)]};
         len = 1;
         case (op)
            addByte: begin
               modelRegs[d] = modelRegs[d] + modelRegs[s];
               len = 2;
            end
            subByte: begin
               modelRegs[d] = modelRegs[d] - modelRegs[s];
               len = 2;
            end
            movImmByte: begin
               modelRegs[d] = imm;
               len = 6;
            end
            addImmByte: begin
               modelRegs[d] = modelRegs[d] + imm;
               len = 6;
            end
            default: len = 1;
         endcase
         if (len > 1) expQ.push_back({d, modelRegs[d]});
         pc += len;
      end
   endtask

   task automatic applyReset(input int startAddr);
      @(posedge bus);
      #1;
      rst = 1'b1;
      entry = 64'(startAddr);
      repeat (10) @(posedge bus);
      #1;
      rst = 1'b0;
      if (reqCyc !== 1'b0 || wb.valid !== 1'b0) begin
         errors++;
         $display("FAIL %0t: reqCyc or wb.valid high at reset release", $time);
      end
   endtask

   task automatic runProgram(input int startAddr, input int endAddr);
      for (int i = 0; i < tailNops; i++) begin
         mem[memIdx(endAddr + i)] = nopByte; // nothing retires right after the program
      end
      runModel(startAddr, endAddr);
      applyReset(startAddr);
      checking = 1'b1;
      while (expQ.size() != 0) @(posedge bus);
      repeat (tailNops / 2) @(posedge bus); // a write-back here is an extra retirement
      checking = 1'b0;
   endtask

   task automatic testReset();
      int start;
      start = 'h148;
      fillMemory();
      progPtr = start;
      putInst(movImmByte, 3, 0, 32'h1234_5678);
      putInst(addByte, 3, 3, '0);
      runProgram(start, progPtr);
      if (firstReqAddr != start / lineBytes * lineBytes) begin
         errors++;
         $display("FAIL %0t: first reqAddr %h, expected %h", $time, firstReqAddr,
            start / lineBytes * lineBytes);
      end
   endtask

   task automatic testMovImm();
      fillMemory();
      progPtr = 0;
      for (int r = 0; r < regCount; r++) begin
         putInst(movImmByte, r, 0, $urandom());
      end
      runProgram(0, progPtr);
   endtask

   task automatic testDependentChain();
      int pick;
      fillMemory();
      progPtr = 'h40;
      putInst(movImmByte, 1, 0, 32'hFFFF_FFFF);
      putInst(movImmByte, 2, 0, $urandom());
      for (int i = 0; i < 34; i++) begin
         putInst(addByte, 1, 1, '0); // r1 doubles and wraps past bit 63
      end
      for (int i = 0; i < 40; i++) begin
         pick = pickReg(3);
         putInst(pick == 0 ? addByte : (pick == 1 ? subByte : addImmByte),
            1 + pickReg(3), 1 + pickReg(3), $urandom());
      end
      runProgram('h40, progPtr);
   endtask

   task automatic testMixedLengths();
      fillMemory();
      progPtr = 'h100;
      while (progPtr < 'h100 + 320) begin
         case ($urandom % 6)
            1: putInst(8'($urandom), 0, 0, '0); // mostly outside the opcode set
            2: putInst(addByte, pickReg(regCount), pickReg(regCount), '0);
            3: putInst(subByte, pickReg(regCount), pickReg(regCount), '0);
            4: putInst(movImmByte, pickReg(regCount), 0, $urandom());
            5: putInst(addImmByte, pickReg(regCount), 0, $urandom());
            default: putInst(nopByte, 0, 0, '0);
         endcase
      end
      runProgram('h100, progPtr);
   endtask

   task automatic testEntryOffset();
      fillMemory();
      progPtr = 'h400;
      for (int i = 0; i < 4; i++) begin
         putInst(movImmByte, i, 0, 32'hDEAD_0000); // 24 bytes ahead of the entry
      end
      putInst(addImmByte, 0, 0, 32'h11);
      putInst(addByte, 1, 0, '0);
      putInst(movImmByte, 2, 0, $urandom());
      runProgram('h418, progPtr);
   endtask

   initial begin
      void'($urandom(42));
      rst = 1'b1;
      entry = '0;
      checking = 1'b0;
      errors = 0;
      testReset();
      testMovImm();
      testDependentChain();
      testMixedLengths();
      testEntryOffset();
      errors += dut.sva.failCount;
      $display("run complete: %0d errors", errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/coreTb_sva.sv
/* Concurrent checks on the bus strobes, issue and write-back of the core,
   bound into every coreTop instance. */
`timescale 1ns/1ps
`default_nettype none

module coreTb_sva import corePkg::*; (
   input logic bus,
   input logic rst,
   input logic reqCyc,
   input logic respCyc,
   input logic issue,
   input logic decodedUseDest,
   input logic [regIdxWidth-1:0] decodedDest,
   input writebackT wb
);

   int failCount = 0; // assertion failures so far

   // no new request while a line is still arriving
   assert property (@(posedge bus) disable iff (rst) !(reqCyc && respCyc))
      else begin
         failCount++;
         $error("reqCyc high during a response beat");
      end

   assert property (@(posedge bus) rst |=> !reqCyc)
      else begin
         failCount++;
         $error("reqCyc high in the cycle after reset");
      end

   // an issued write retires two cycles later
   assert property (@(posedge bus) disable iff (rst)
         $past(issue && decodedUseDest, 2)
            |-> (wb.valid && wb.regIdx == $past(decodedDest, 2)))
      else begin
         failCount++;
         $error("issued write did not reach write-back two cycles later");
      end

   // back to back retirements of one register need an issue in between
   assert property (@(posedge bus) disable iff (rst)
         (wb.valid && $past(wb.valid) && wb.regIdx == $past(wb.regIdx)) |-> $past(issue))
      else begin
         failCount++;
         $error("repeated write-back to r%0d", wb.regIdx);
      end

endmodule

bind coreTop coreTb_sva sva (
   .bus(bus), .rst(rst), .reqCyc(reqCyc), .respCyc(respCyc),
   .issue(issue), .decodedUseDest(decoded.useDest), .decodedDest(decoded.destReg), .wb(wb)
);

`default_nettype wire

// File: vlog.f
common/corePkg.sv
fetch/fetchUnit.sv
source/instDecoder.sv
source/scoreboard.sv
source/regRead.sv
source/aluExecute.sv
source/coreTop.sv
testbench/coreTb_sva.sv
testbench/coreTb.sv
